// ==== bench/axi_mem_model.sv ====
`timescale 1ns/1ps

module axi_mem_model import axi_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        load_en,
  input  logic [31:0] load_addr,
  input  logic [31:0] load_data,
  input  logic        arvalid,
  input  logic [31:0] araddr,
  output logic        arready,
  output logic        rvalid,
  output logic [63:0] rdata,
  output logic [1:0]  rresp,
  output logic        rlast,
  output logic [3:0]  rid,
  input  logic        rready,
  input  logic        awvalid,
  input  logic [31:0] awaddr,
  output logic        awready,
  input  logic        wvalid,
  input  logic [63:0] wdata,
  input  logic [7:0]  wstrb,
  output logic        wready,
  output logic        bvalid,
  output logic [1:0]  bresp,
  output logic [3:0]  bid,
  input  logic        bready,
  output logic [31:0] store_count,
  output logic [31:0] store_addr,
  output logic [31:0] store_data,
  output logic [7:0]  store_strb
);

  // 2 KB window of 64-bit words
  logic [63:0] mem [0:255];
  logic [31:0] rd_addr;
  logic [31:0] wr_addr;
  logic [63:0] wr_data;
  logic [7:0]  wr_strb;
  logic [63:0] wr_mask;
  logic        rd_pend;
  logic        aw_got;
  logic        w_got;
  logic        commit;
  int unsigned ar_wait;
  int unsigned r_wait;
  int unsigned aw_wait;
  int unsigned w_wait;
  int unsigned b_wait;

  assign rdata  = mem[rd_addr[10:3]];
  assign rresp  = AXI_RESP_OKAY;
  assign rlast  = 1'b1;
  assign rid    = '0;
  assign bresp  = AXI_RESP_OKAY;
  assign bid    = '0;
  assign commit = aw_got && w_got && !bvalid && b_wait == 0;
  assign wr_mask = {{8{wr_strb[7]}}, {8{wr_strb[6]}}, {8{wr_strb[5]}}, {8{wr_strb[4]}},
                    {8{wr_strb[3]}}, {8{wr_strb[2]}}, {8{wr_strb[1]}}, {8{wr_strb[0]}}};

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      arready     <= 1'b0;
      rvalid      <= 1'b0;
      awready     <= 1'b0;
      wready      <= 1'b0;
      bvalid      <= 1'b0;
      rd_pend     <= 1'b0;
      aw_got      <= 1'b0;
      w_got       <= 1'b0;
      rd_addr     <= '0;
      ar_wait     <= 0;
      r_wait      <= 0;
      aw_wait     <= 0;
      w_wait      <= 0;
      b_wait      <= 0;
      store_count <= '0;
      store_addr  <= '0;
      store_data  <= '0;
      store_strb  <= '0;
    end else begin
      // read address, data follows after a random gap
      if (arvalid && arready) begin
        arready <= 1'b0;
        rd_addr <= araddr;
        rd_pend <= 1'b1;
        ar_wait <= $urandom_range(3, 0);
        r_wait  <= $urandom_range(3, 0);
      end else if (arvalid && !rd_pend) begin
        if (ar_wait == 0) arready <= 1'b1;
        else ar_wait <= ar_wait - 1;
      end
      if (rvalid && rready) begin
        rvalid  <= 1'b0;
        rd_pend <= 1'b0;
      end else if (rd_pend && !rvalid) begin
        if (r_wait == 0) rvalid <= 1'b1;
        else r_wait <= r_wait - 1;
      end
      // aw and w accepted on their own schedules
      if (awvalid && awready) begin
        awready <= 1'b0;
        aw_got  <= 1'b1;
        wr_addr <= awaddr;
        aw_wait <= $urandom_range(3, 0);
        b_wait  <= $urandom_range(3, 0);
      end else if (awvalid && !aw_got) begin
        if (aw_wait == 0) awready <= 1'b1;
        else aw_wait <= aw_wait - 1;
      end
      if (wvalid && wready) begin
        wready  <= 1'b0;
        w_got   <= 1'b1;
        wr_data <= wdata;
        wr_strb <= wstrb;
        w_wait  <= $urandom_range(3, 0);
      end else if (wvalid && !w_got) begin
        if (w_wait == 0) wready <= 1'b1;
        else w_wait <= w_wait - 1;
      end
      if (bvalid && bready) begin
        bvalid <= 1'b0;
        aw_got <= 1'b0;
        w_got  <= 1'b0;
      end else if (commit) begin
        bvalid      <= 1'b1;
        store_count <= store_count + 1;
        store_addr  <= wr_addr;
        store_data  <= wr_strb[4] ? wr_data[63:32] : wr_data[31:0];
        store_strb  <= wr_strb;
      end else if (aw_got && w_got && !bvalid) begin
        b_wait <= b_wait - 1;
      end
    end
  end

  // program loads win over bus stores
  always_ff @(posedge clock) begin
    if (load_en) begin
      if (load_addr[2]) mem[load_addr[10:3]][63:32] <= load_data;
      else mem[load_addr[10:3]][31:0] <= load_data;
    end else if (rst_n && commit) begin
      mem[wr_addr[10:3]] <= (mem[wr_addr[10:3]] & ~wr_mask) | (wr_data & wr_mask);
    end
  end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import rv_isa_pkg::*; ();

  localparam int NUM_TESTS      = 11;
  localparam int TIMEOUT_CYCLES = 2000;

  localparam logic [31:0] ADDR_HI = RESET_PC + 32'h104;
  localparam logic [31:0] ADDR_LO = RESET_PC + 32'h100;

  // lui x1, 0x80000 gives the data base
  localparam logic [31:0] LUI_X1   = 32'h800000B7;
  // addi x2, x0, 100 and addi x3, x0, -7
  localparam logic [31:0] LI_X2    = 32'h06400113;
  localparam logic [31:0] LI_X3    = 32'hFF900193;
  // sw x4 to base+0x104 and base+0x100
  localparam logic [31:0] SW_X4_HI = 32'h1040A223;
  localparam logic [31:0] SW_X4_LO = 32'h1040A023;
  localparam logic [31:0] EBRK     = 32'h00100073;

  typedef struct packed {
    logic [0:7][31:0] prog;
    logic [31:0]      exp_addr;
    logic [31:0]      exp_data;
    logic             halt_only;
  } test_row_t;

  localparam test_row_t TESTS [NUM_TESTS] = '{
    '{prog: '{LUI_X1, LI_X2, LI_X3, 32'h00310233, SW_X4_HI, EBRK, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'd93, halt_only: 1'b0},
    '{prog: '{LUI_X1, LI_X2, LI_X3, 32'h40310233, SW_X4_HI, EBRK, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'd107, halt_only: 1'b0},
    '{prog: '{LUI_X1, LI_X2, LI_X3, 32'h00317233, SW_X4_HI, EBRK, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'h0000_0060, halt_only: 1'b0},
    '{prog: '{LUI_X1, LI_X2, LI_X3, 32'h00316233, SW_X4_HI, EBRK, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'hFFFF_FFFD, halt_only: 1'b0},
    '{prog: '{LUI_X1, LI_X2, LI_X3, 32'h00314233, SW_X4_HI, EBRK, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'hFFFF_FF9D, halt_only: 1'b0},
    // slt x4, x3, x2 with -7 < 100
    '{prog: '{LUI_X1, LI_X2, LI_X3, 32'h0021A233, SW_X4_HI, EBRK, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'd1, halt_only: 1'b0},
    // lui 0xDEADC then addi -0x111
    '{prog: '{LUI_X1, 32'hDEADC237, 32'hEEF20213, SW_X4_LO, EBRK, EBRK, EBRK, EBRK},
      exp_addr: ADDR_LO, exp_data: 32'hDEAD_BEEF, halt_only: 1'b0},
    // sw x2 to base+0x10c, lw x5 back, addi x4, x5, 1
    '{prog: '{LUI_X1, LI_X2, 32'h1020A623, 32'h10C0A283, 32'h00128213, SW_X4_HI, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'd101, halt_only: 1'b0},
    // beq skips addi x4, x0, -1 and bne falls into addi x4, x4, 42
    '{prog: '{LUI_X1, 32'h00000463, 32'hFFF00213, 32'h00001463, 32'h02A20213, SW_X4_HI,
              EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'd42, halt_only: 1'b0},
    '{prog: '{LUI_X1, 32'h03700013, 32'h1000A223, EBRK, EBRK, EBRK, EBRK, EBRK},
      exp_addr: ADDR_HI, exp_data: 32'd0, halt_only: 1'b0},
    '{prog: '{LUI_X1, LI_X2, 32'hFFFF_FFFF, 32'h1020A223, EBRK, EBRK, EBRK, EBRK},
      exp_addr: '0, exp_data: '0, halt_only: 1'b1}
  };

  string names [NUM_TESTS] = '{"add", "sub", "and", "or", "xor", "slt", "lui_addi",
                               "load_use", "branch", "x0_zero", "illegal"};

  logic        clock;
  logic        rst_n;
  logic        load_en;
  logic [31:0] load_addr, load_data;
  logic        arvalid, arready, rvalid, rready, rlast;
  logic        awvalid, awready, wvalid, wready, wlast, bvalid, bready, halted;
  logic [31:0] araddr, awaddr, store_count, store_addr, store_data;
  logic [63:0] rdata, wdata;
  logic [7:0]  arlen, awlen, wstrb, store_strb;
  logic [3:0]  arid, awid, rid, bid;
  logic [2:0]  arsize, awsize;
  logic [1:0]  arburst, awburst, rresp, bresp;
  int          test_errors;
  int          cur_test;

  rv_soc_top dut0 (
    .clock(clock), .rst_n(rst_n), .halted(halted),
    .io_master_arready(arready), .io_master_arvalid(arvalid), .io_master_araddr(araddr),
    .io_master_arid(arid), .io_master_arlen(arlen), .io_master_arsize(arsize),
    .io_master_arburst(arburst),
    .io_master_rready(rready), .io_master_rvalid(rvalid), .io_master_rresp(rresp),
    .io_master_rdata(rdata), .io_master_rlast(rlast), .io_master_rid(rid),
    .io_master_awready(awready), .io_master_awvalid(awvalid), .io_master_awaddr(awaddr),
    .io_master_awid(awid), .io_master_awlen(awlen), .io_master_awsize(awsize),
    .io_master_awburst(awburst),
    .io_master_wready(wready), .io_master_wvalid(wvalid), .io_master_wdata(wdata),
    .io_master_wstrb(wstrb), .io_master_wlast(wlast),
    .io_master_bready(bready), .io_master_bvalid(bvalid), .io_master_bresp(bresp),
    .io_master_bid(bid)
  );

  axi_mem_model mem0 (
    .clock(clock), .rst_n(rst_n),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data),
    .arvalid(arvalid), .araddr(araddr), .arready(arready),
    .rvalid(rvalid), .rdata(rdata), .rresp(rresp), .rlast(rlast), .rid(rid), .rready(rready),
    .awvalid(awvalid), .awaddr(awaddr), .awready(awready),
    .wvalid(wvalid), .wdata(wdata), .wstrb(wstrb), .wready(wready),
    .bvalid(bvalid), .bresp(bresp), .bid(bid), .bready(bready),
    .store_count(store_count), .store_addr(store_addr), .store_data(store_data),
    .store_strb(store_strb)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // word lane strobe for a 64-bit bus
  function automatic logic [31:0] lane_strobe(input logic [31:0] addr);
    return addr[2] ? 32'h0000_00F0 : 32'h0000_000F;
  endfunction

  task automatic compare_value(input string test_name, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error: %s %s expected %h actual %h", test_name, field, expected, actual);
      test_errors++;
    end
  endtask

  // every transfer is one beat of 4 bytes, INCR, id 0
  always @(posedge clock) begin
    if (arvalid && arready) begin
      compare_value(names[cur_test], "ar id/len/size/burst",
                    {15'd0, 4'd0, 8'd0, 3'b010, 2'b01},
                    {15'd0, arid, arlen, arsize, arburst});
    end
    if (awvalid && awready) begin
      compare_value(names[cur_test], "aw id/len/size/burst",
                    {15'd0, 4'd0, 8'd0, 3'b010, 2'b01},
                    {15'd0, awid, awlen, awsize, awburst});
    end
    if (wvalid && wready) begin
      compare_value(names[cur_test], "wlast", 32'd1, {31'd0, wlast});
    end
  end

  initial begin
    int pass_count;
    int fail_count;
    int cycles;
    pass_count = 0;
    fail_count = 0;
    void'($urandom(32'h40e64108));
    rst_n     = 1'b0;
    load_en   = 1'b0;
    load_addr = '0;
    load_data = '0;
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test    = t;
      test_errors = 0;
      // program goes in while the core sits in reset
      for (int c = 0; c < 16; c++) begin
        @(posedge clock);
        rst_n     <= 1'b0;
        load_en   <= c < 8;
        load_addr <= RESET_PC + 32'(c * 4);
        load_data <= TESTS[t].prog[c[2:0]];
      end
      @(posedge clock);
      rst_n   <= 1'b1;
      load_en <= 1'b0;
      cycles = 0;
      @(negedge clock);
      while (!halted && cycles < TIMEOUT_CYCLES) begin
        @(negedge clock);
        cycles++;
      end
      if (!halted) begin
        $display("%s: core did not halt within %0d cycles", names[t], TIMEOUT_CYCLES);
        test_errors++;
      end else if (TESTS[t].halt_only) begin
        compare_value(names[t], "store count", 32'd0, store_count);
      end else if (store_count == 0) begin
        $display("%s: program halted without storing a result", names[t]);
        test_errors++;
      end else begin
        compare_value(names[t], "store address", TESTS[t].exp_addr, store_addr);
        compare_value(names[t], "store data", TESTS[t].exp_data, store_data);
        compare_value(names[t], "store strobe", lane_strobe(TESTS[t].exp_addr),
                      {24'd0, store_strb});
      end
      if (test_errors == 0) begin
        $display("%s: passed", names[t]);
        pass_count++;
      end else begin
        $display("%s: failed", names[t]);
        fail_count++;
      end
    end
    $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== hw/axi_master_port.sv ====
`timescale 1ns/1ps

module axi_master_port import axi_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        req_valid,
  input  logic        req_write,
  input  logic [31:0] req_addr,
  input  logic [31:0] req_wdata,
  output logic        req_done,
  output logic [31:0] rsp_rdata,
  output logic        rsp_err,
  output axi_ar_t     ar,
  output logic        arvalid,
  input  logic        arready,
  input  axi_r_t      r,
  input  logic        rvalid,
  output logic        rready,
  output axi_aw_t     aw,
  output logic        awvalid,
  input  logic        awready,
  output axi_w_t      w,
  output logic        wvalid,
  input  logic        wready,
  input  axi_b_t      b,
  input  logic        bvalid,
  output logic        bready
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ADDR,
    S_RESP
  } state_e;

  state_e      state;
  logic        write_q;
  logic [31:0] addr_q;
  logic [31:0] wdata_q;
  logic        lane_hi;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state   <= S_IDLE;
      write_q <= 1'b0;
      arvalid <= 1'b0;
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      rready  <= 1'b0;
      bready  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req_valid) begin
            write_q <= req_write;
            arvalid <= !req_write;
            awvalid <= req_write;
            wvalid  <= req_write;
            state   <= S_ADDR;
          end
        end
        S_ADDR: begin
          if (write_q) begin
            // aw and w complete independently
            if (awready) awvalid <= 1'b0;
            if (wready) wvalid <= 1'b0;
            if ((awready || !awvalid) && (wready || !wvalid)) begin
              bready <= 1'b1;
              state  <= S_RESP;
            end
          end else if (arready) begin
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= S_RESP;
          end
        end
        S_RESP: begin
          if (req_done) begin
            rready <= 1'b0;
            bready <= 1'b0;
            state  <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == S_IDLE && req_valid) begin
      addr_q  <= req_addr;
      wdata_q <= req_wdata;
    end
  end

  assign lane_hi = addr_q[2];

  assign ar = '{addr: addr_q, id: '0, len: '0, size: AXI_SIZE_4B, burst: AXI_BURST_INCR};
  assign aw = '{addr: addr_q, id: '0, len: '0, size: AXI_SIZE_4B, burst: AXI_BURST_INCR};
  assign w  = '{data: {2{wdata_q}}, strb: lane_hi ? 8'hF0 : 8'h0F, last: 1'b1};

  assign req_done  = (state == S_RESP) && (write_q ? (bvalid && bready) : (rvalid && rready));
  assign rsp_rdata = lane_hi ? r.data[63:32] : r.data[31:0];
  assign rsp_err   = req_done && ((write_q ? b.resp : r.resp) != AXI_RESP_OKAY);

  assert property (@(posedge clock) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(ar.addr));

  // w payload held until accepted
  assert property (@(posedge clock) disable iff (!rst_n)
    wvalid && !wready |=> wvalid && $stable(w));

  assert property (@(posedge clock) disable iff (!rst_n) req_done |-> req_valid);

endmodule

// ==== hw/axi_pkg.sv ====
package axi_pkg;

  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_ID_W   = 4;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  localparam logic [2:0] AXI_SIZE_4B    = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;
  localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ID_W-1:0]   id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_ar_t;

  typedef struct packed {
    logic [AXI_ADDR_W-1:0] addr;
    logic [AXI_ID_W-1:0]   id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_aw_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [AXI_STRB_W-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [AXI_DATA_W-1:0] data;
    logic [1:0]            resp;
    logic                  last;
    logic [AXI_ID_W-1:0]   id;
  } axi_r_t;

  typedef struct packed {
    logic [1:0]          resp;
    logic [AXI_ID_W-1:0] id;
  } axi_b_t;

endpackage

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps

module rv_core import rv_isa_pkg::*, axi_pkg::*; (
  input  logic    clock,
  input  logic    rst_n,
  output logic    halted,
  output axi_ar_t ar,
  output logic    arvalid,
  input  logic    arready,
  input  axi_r_t  r,
  input  logic    rvalid,
  output logic    rready,
  output axi_aw_t aw,
  output logic    awvalid,
  input  logic    awready,
  output axi_w_t  w,
  output logic    wvalid,
  input  logic    wready,
  input  axi_b_t  b,
  input  logic    bvalid,
  output logic    bready
);

  typedef enum logic [2:0] {
    C_FETCH,
    C_EXECUTE,
    C_MEM,
    C_WRITEBACK,
    C_HALT
  } core_state_e;

  core_state_e state;
  logic [31:0] pc_q;
  logic [31:0] ir_q;
  logic [31:0] load_q;
  decoded_t    dec;
  logic [31:0] rs1_val;
  logic [31:0] rs2_val;
  logic [31:0] alu_result;
  logic [31:0] mem_addr;
  logic [31:0] next_pc;
  logic        req_valid;
  logic        req_write;
  logic [31:0] req_addr;
  logic        req_done;
  logic [31:0] rsp_rdata;
  logic        rsp_err;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      state <= C_FETCH;
      pc_q  <= RESET_PC;
      ir_q  <= '0;
    end else begin
      case (state)
        C_FETCH: begin
          if (req_done) begin
            ir_q  <= rsp_rdata;
            state <= rsp_err ? C_HALT : C_EXECUTE;
          end
        end
        C_EXECUTE: begin
          if (dec.illegal || dec.is_halt) state <= C_HALT;
          else if (dec.is_load || dec.is_store) state <= C_MEM;
          else state <= C_WRITEBACK;
        end
        C_MEM: begin
          if (req_done) state <= rsp_err ? C_HALT : C_WRITEBACK;
        end
        C_WRITEBACK: begin
          pc_q  <= next_pc;
          state <= C_FETCH;
        end
        // halt is sticky until reset
        default: state <= C_HALT;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == C_MEM && req_done) load_q <= rsp_rdata;
  end

  assign halted    = state == C_HALT;
  assign req_valid = (state == C_FETCH) || (state == C_MEM);
  assign req_write = (state == C_MEM) && dec.is_store;
  assign req_addr  = (state == C_FETCH) ? pc_q : mem_addr;

  rv_decode u_decode (.instr(ir_q), .dec(dec));

  rv_execute u_execute (
    .dec(dec), .pc(pc_q), .rs1_val(rs1_val), .rs2_val(rs2_val),
    .alu_result(alu_result), .mem_addr(mem_addr), .next_pc(next_pc)
  );

  rv_result u_result (
    .clock(clock), .rst_n(rst_n), .dec(dec), .wb_en(state == C_WRITEBACK),
    .alu_result(alu_result), .load_data(load_q), .rs1_val(rs1_val), .rs2_val(rs2_val)
  );

  axi_master_port u_port (
    .clock(clock), .rst_n(rst_n),
    .req_valid(req_valid), .req_write(req_write), .req_addr(req_addr),
    .req_wdata(rs2_val), .req_done(req_done), .rsp_rdata(rsp_rdata), .rsp_err(rsp_err),
    .ar(ar), .arvalid(arvalid), .arready(arready),
    .r(r), .rvalid(rvalid), .rready(rready),
    .aw(aw), .awvalid(awvalid), .awready(awready),
    .w(w), .wvalid(wvalid), .wready(wready),
    .b(b), .bvalid(bvalid), .bready(bready)
  );

  // branch offsets may carry bit 1
  assert property (@(posedge clock) disable iff (!rst_n) pc_q[1:0] == 2'b00);

endmodule

// ==== hw/rv_decode.sv ====
`timescale 1ns/1ps

module rv_decode import rv_isa_pkg::*; (
  input  logic [31:0] instr,
  output decoded_t    dec
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};

  always_comb begin
    dec        = '0;
    dec.rd     = instr[11:7];
    dec.rs1    = instr[19:15];
    dec.rs2    = instr[24:20];
    dec.alu_op = ALU_ADD;
    dec.wb_sel = WB_ALU;
    case (opcode)
      OPC_OP_IMM: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        // addi only
        dec.illegal   = funct3 != 3'b000;
      end
      OPC_OP: begin
        dec.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec.alu_op = ALU_ADD;
          {7'h20, 3'b000}: dec.alu_op = ALU_SUB;
          {7'h00, 3'b111}: dec.alu_op = ALU_AND;
          {7'h00, 3'b110}: dec.alu_op = ALU_OR;
          {7'h00, 3'b100}: dec.alu_op = ALU_XOR;
          {7'h00, 3'b010}: dec.alu_op = ALU_SLT;
          default:         dec.illegal = 1'b1;
        endcase
      end
      OPC_LUI: begin
        dec.imm       = imm_u;
        dec.use_imm   = 1'b1;
        dec.alu_op    = ALU_PASS_B;
        dec.reg_write = 1'b1;
      end
      OPC_LOAD: begin
        dec.imm       = imm_i;
        dec.use_imm   = 1'b1;
        dec.reg_write = 1'b1;
        dec.wb_sel    = WB_LOAD;
        dec.is_load   = 1'b1;
        dec.illegal   = funct3 != 3'b010;
      end
      OPC_STORE: begin
        dec.imm      = imm_s;
        dec.is_store = 1'b1;
        dec.illegal  = funct3 != 3'b010;
      end
      OPC_BRANCH: begin
        dec.imm       = imm_b;
        dec.is_branch = 1'b1;
        dec.branch_ne = funct3[0];
        // beq and bne only
        dec.illegal   = funct3[2:1] != 2'b00;
      end
      OPC_SYSTEM: begin
        dec.is_halt = instr == INSTR_EBREAK;
        dec.illegal = instr != INSTR_EBREAK;
      end
      default: dec.illegal = 1'b1;
    endcase
  end

endmodule

// ==== hw/rv_execute.sv ====
`timescale 1ns/1ps

module rv_execute import rv_isa_pkg::*; (
  input  decoded_t    dec,
  input  logic [31:0] pc,
  input  logic [31:0] rs1_val,
  input  logic [31:0] rs2_val,
  output logic [31:0] alu_result,
  output logic [31:0] mem_addr,
  output logic [31:0] next_pc
);

  logic [31:0] op_b;
  logic        equal;
  logic        taken;

  assign op_b = dec.use_imm ? dec.imm : rs2_val;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_result = rs1_val + op_b;
      ALU_SUB:    alu_result = rs1_val - op_b;
      ALU_AND:    alu_result = rs1_val & op_b;
      ALU_OR:     alu_result = rs1_val | op_b;
      ALU_XOR:    alu_result = rs1_val ^ op_b;
      ALU_SLT:    alu_result = {31'b0, $signed(rs1_val) < $signed(op_b)};
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // loads and stores share the I/S immediate slot
  assign mem_addr = rs1_val + dec.imm;

  assign equal   = rs1_val == rs2_val;
  assign taken   = dec.is_branch && (equal ^ dec.branch_ne);
  assign next_pc = taken ? pc + dec.imm : pc + 32'd4;

endmodule

// ==== hw/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // first fetch address after reset
  localparam logic [31:0] RESET_PC = 32'h8000_0000;

  // major opcodes of the supported subset
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  localparam logic [31:0] INSTR_EBREAK = 32'h0010_0073;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic {
    WB_ALU,
    WB_LOAD
  } wb_sel_e;

  typedef struct packed {
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    logic        use_imm;
    logic        reg_write;
    wb_sel_e     wb_sel;
    logic        is_load;
    logic        is_store;
    logic        is_branch;
    logic        branch_ne;
    logic        is_halt;
    logic        illegal;
  } decoded_t;

endpackage

// ==== hw/rv_result.sv ====
`timescale 1ns/1ps

module rv_result import rv_isa_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  decoded_t    dec,
  input  logic        wb_en,
  input  logic [31:0] alu_result,
  input  logic [31:0] load_data,
  output logic [31:0] rs1_val,
  output logic [31:0] rs2_val
);

  logic [31:0] regs [31:1];
  logic [31:0] wb_data;

  assign wb_data = (dec.wb_sel == WB_LOAD) ? load_data : alu_result;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en && dec.reg_write && dec.rd != 5'd0) begin
      regs[dec.rd] <= wb_data;
    end
  end

  // x0 is hardwired
  assign rs1_val = (dec.rs1 == 5'd0) ? 32'd0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == 5'd0) ? 32'd0 : regs[dec.rs2];

  // writeback never spans two cycles
  assert property (@(posedge clock) disable iff (!rst_n) wb_en |=> !wb_en);

endmodule

// ==== hw/rv_soc_top.sv ====
`timescale 1ns/1ps

module rv_soc_top import axi_pkg::*; (
  input  logic        clock,
  input  logic        rst_n,
  input  logic        io_master_arready,
  output logic        io_master_arvalid,
  output logic [31:0] io_master_araddr,
  output logic [3:0]  io_master_arid,
  output logic [7:0]  io_master_arlen,
  output logic [2:0]  io_master_arsize,
  output logic [1:0]  io_master_arburst,
  output logic        io_master_rready,
  input  logic        io_master_rvalid,
  input  logic [1:0]  io_master_rresp,
  input  logic [63:0] io_master_rdata,
  input  logic        io_master_rlast,
  input  logic [3:0]  io_master_rid,
  input  logic        io_master_awready,
  output logic        io_master_awvalid,
  output logic [31:0] io_master_awaddr,
  output logic [3:0]  io_master_awid,
  output logic [7:0]  io_master_awlen,
  output logic [2:0]  io_master_awsize,
  output logic [1:0]  io_master_awburst,
  input  logic        io_master_wready,
  output logic        io_master_wvalid,
  output logic [63:0] io_master_wdata,
  output logic [7:0]  io_master_wstrb,
  output logic        io_master_wlast,
  output logic        io_master_bready,
  input  logic        io_master_bvalid,
  input  logic [1:0]  io_master_bresp,
  input  logic [3:0]  io_master_bid,
  output logic        halted
);

  axi_ar_t ar;
  axi_aw_t aw;
  axi_w_t  w;
  axi_r_t  r;
  axi_b_t  b;

  // flat pins follow struct field order
  assign {io_master_araddr, io_master_arid, io_master_arlen, io_master_arsize,
          io_master_arburst} = ar;
  assign {io_master_awaddr, io_master_awid, io_master_awlen, io_master_awsize,
          io_master_awburst} = aw;
  assign {io_master_wdata, io_master_wstrb, io_master_wlast} = w;
  assign r = {io_master_rdata, io_master_rresp, io_master_rlast, io_master_rid};
  assign b = {io_master_bresp, io_master_bid};

  rv_core u_core (
    .clock  (clock),
    .rst_n  (rst_n),
    .halted (halted),
    .ar     (ar),
    .arvalid(io_master_arvalid),
    .arready(io_master_arready),
    .r      (r),
    .rvalid (io_master_rvalid),
    .rready (io_master_rready),
    .aw     (aw),
    .awvalid(io_master_awvalid),
    .awready(io_master_awready),
    .w      (w),
    .wvalid (io_master_wvalid),
    .wready (io_master_wready),
    .b      (b),
    .bvalid (io_master_bvalid),
    .bready (io_master_bready)
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim &&
  ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^TEST RESULT: PASS$" sim.log && exit 0 || exit 1

// ==== tb.f ====
hw/rv_isa_pkg.sv
hw/axi_pkg.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/axi_master_port.sv
hw/rv_core.sv
hw/rv_soc_top.sv
bench/axi_mem_model.sv
bench/tb_top.sv
